//--- flist.f
rtl/eeprom_pkg.sv
rtl/serial_bus_if.sv
rtl/bit_timer.sv
rtl/byte_engine.sv
rtl/eeprom_seq_fsm.sv
rtl/eeprom_wr_top.sv
tests/eeprom_model.sv
tests/tb_eeprom_wr.sv

//--- rtl/bit_timer.sv
`timescale 1ns/10ps

module bit_timer import eeprom_pkg::*; #(
    parameter int QUARTER_CYCLES = 2
) (
    input  logic   CLK,
    input  logic   RESET,
    input  logic   timer_run,
    output logic   quarter_tick,
    output phase_t phase
);

    localparam int CW = $clog2(QUARTER_CYCLES) + 1;
    localparam logic [CW-1:0] RELOAD = CW'(QUARTER_CYCLES - 1);

    logic [CW-1:0] cnt;

    assign quarter_tick = timer_run && (cnt == '0);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            cnt   <= RELOAD;
            phase <= '0;
        end else if (!timer_run) begin
            // held cleared so each command starts at phase 0
            cnt   <= RELOAD;
            phase <= '0;
        end else if (cnt == '0) begin
            cnt   <= RELOAD;
            phase <= phase + 2'd1;    // wraps 3 -> 0
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- rtl/byte_engine.sv
`timescale 1ns/10ps

module byte_engine import eeprom_pkg::*; (
    input  logic         CLK,
    input  logic         RESET,
    serial_bus_if.engine bus,
    input  logic         quarter_tick,
    input  phase_t       phase,
    output logic         timer_run,
    output logic         scl,
    output logic         sda_pull_low,
    input  logic         sda_in
);

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_COND,    // start or stop condition, one bit time
        ENG_BITS     // eight data bits plus the ack slot
    } eng_state_t;

    eng_state_t state;
    logic       is_start;
    logic       cmd_done_q;
    logic [8:0] shreg;       // bits out at the top, sampled bits in at the bottom
    logic [8:0] tx_word;
    logic [3:0] bit_cnt;
    logic       accept;

    assign accept    = (state == ENG_IDLE) && bus.cmd_valid;
    assign timer_run = (state != ENG_IDLE);

    // a read releases sda for the data bits and drives the ack slot itself
    assign tx_word = (bus.cmd == CMD_READ) ? {8'hff, bus.master_nack} : {bus.tx_byte, 1'b1};

    assign bus.cmd_done  = cmd_done_q;
    assign bus.rx_byte   = shreg[8:1];
    assign bus.slave_ack = shreg[0];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= ENG_IDLE;
            is_start     <= 1'b0;
            bit_cnt      <= '0;
            cmd_done_q   <= 1'b0;
            scl          <= 1'b1;
            sda_pull_low <= 1'b0;
        end else begin
            cmd_done_q <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (accept) begin
                        bit_cnt <= '0;
                        case (bus.cmd)
                            CMD_START: begin
                                state        <= ENG_COND;
                                is_start     <= 1'b1;
                                sda_pull_low <= 1'b0;    // release, works as repeated start
                            end
                            CMD_STOP: begin
                                state        <= ENG_COND;
                                is_start     <= 1'b0;
                                sda_pull_low <= 1'b1;
                            end
                            default: begin
                                state        <= ENG_BITS;
                                sda_pull_low <= !tx_word[8];
                            end
                        endcase
                    end
                end
                ENG_COND: begin
                    if (quarter_tick) begin
                        case (phase)
                            2'd0: scl <= 1'b1;
                            2'd1: sda_pull_low <= is_start;  // sda edge while scl high
                            2'd2: scl <= is_start ? 1'b0 : 1'b1;
                            default: begin
                                state      <= ENG_IDLE;
                                cmd_done_q <= 1'b1;
                            end
                        endcase
                    end
                end
                ENG_BITS: begin
                    if (quarter_tick) begin
                        case (phase)
                            2'd0: scl <= 1'b1;
                            2'd2: scl <= 1'b0;   // sampled on this tick too
                            2'd3: begin
                                if (bit_cnt == 4'd8) begin
                                    state      <= ENG_IDLE;
                                    cmd_done_q <= 1'b1;
                                end else begin
                                    bit_cnt      <= bit_cnt + 4'd1;
                                    sda_pull_low <= !shreg[8];
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            shreg <= tx_word;
        end else if (state == ENG_BITS && quarter_tick && phase == 2'd2) begin
            shreg <= {shreg[7:0], sda_in};
        end
    end

endmodule

//--- rtl/eeprom_pkg.sv
package eeprom_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [10:0] mem_addr_t;
    typedef logic [1:0]  phase_t;    // quarter index within one scl bit

    // byte-level commands from the sequencer to the bit engine
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_t;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR_WR,
        DATA_WR,
        RESTART,     // repeated start before the read control byte
        CTRL_RD,
        DATA_RD,
        STOP,
        DONE
    } seq_state_t;

    localparam logic [3:0] DEV_TYPE = 4'b1010;   // serial eeprom type code

endpackage

//--- rtl/eeprom_seq_fsm.sv
`timescale 1ns/10ps

module eeprom_seq_fsm import eeprom_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      wr,
    input  logic      rd,
    input  mem_addr_t addr,
    input  byte_t     wdata,
    output byte_t     rdata,
    output logic      ack,
    output logic      err,
    output logic      busy,
    serial_bus_if.seq bus
);

    seq_state_t state;
    seq_state_t done_next;

    logic      op_read;
    logic      cmd_sent;     // command of the current state already issued
    logic      err_flag;
    logic      nack_abort;
    mem_addr_t addr_q;
    byte_t     wdata_q;
    bus_cmd_t  cmd_sel;
    byte_t     tx_sel;

    assign ack  = (state == DONE);
    assign err  = err_flag;
    assign busy = (state != IDLE);

    assign bus.cmd_valid   = (state != IDLE) && (state != DONE) && !cmd_sent;
    assign bus.cmd         = cmd_sel;
    assign bus.tx_byte     = tx_sel;
    assign bus.master_nack = (state == DATA_RD);   // single byte reads end with nack

    // command and byte for the current state
    always_comb begin
        cmd_sel = CMD_WRITE;
        tx_sel  = addr_q[7:0];
        case (state)
            START, RESTART: cmd_sel = CMD_START;
            STOP:           cmd_sel = CMD_STOP;
            DATA_RD:        cmd_sel = CMD_READ;
            CTRL_WR:        tx_sel  = {DEV_TYPE, addr_q[10:8], 1'b0};
            CTRL_RD:        tx_sel  = {DEV_TYPE, addr_q[10:8], 1'b1};
            DATA_WR:        tx_sel  = wdata_q;
            default: ;
        endcase
    end

    // a written byte without slave ack aborts the operation
    assign nack_abort = (cmd_sel == CMD_WRITE) && bus.slave_ack;

    always_comb begin
        case (state)
            START:   done_next = CTRL_WR;
            CTRL_WR: done_next = ADDR_WR;
            ADDR_WR: done_next = op_read ? RESTART : DATA_WR;
            DATA_WR: done_next = STOP;
            RESTART: done_next = CTRL_RD;
            CTRL_RD: done_next = DATA_RD;
            DATA_RD: done_next = STOP;
            STOP:    done_next = DONE;
            default: done_next = IDLE;
        endcase
        if (nack_abort) begin
            done_next = STOP;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= IDLE;
            op_read  <= 1'b0;
            cmd_sent <= 1'b0;
            err_flag <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr || rd) begin
                        op_read  <= !wr;    // write wins when both are high
                        err_flag <= 1'b0;
                        cmd_sent <= 1'b0;
                        state    <= START;
                    end
                end
                DONE: state <= IDLE;
                default: begin
                    if (!cmd_sent) begin
                        cmd_sent <= 1'b1;
                    end else if (bus.cmd_done) begin
                        cmd_sent <= 1'b0;
                        state    <= done_next;
                        if (nack_abort) begin
                            err_flag <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // request payload, taken only when an operation is accepted
    always_ff @(posedge CLK) begin
        if (state == IDLE && (wr || rd)) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == DATA_RD && cmd_sent && bus.cmd_done) begin
            rdata <= bus.rx_byte;
        end
    end

endmodule

//--- rtl/eeprom_wr_top.sv
`timescale 1ns/10ps

module eeprom_wr_top import eeprom_pkg::*; #(
    parameter int QUARTER_CYCLES = 2
) (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      wr,
    input  logic      rd,
    input  mem_addr_t addr,
    input  byte_t     wdata,
    output byte_t     rdata,
    output logic      ack,
    output logic      err,
    output logic      busy,
    output logic      scl,
    output logic      sda_pull_low,
    input  logic      sda_in
);

    logic   timer_run;
    logic   quarter_tick;
    phase_t phase;

    serial_bus_if bus ();

    bit_timer #(
        .QUARTER_CYCLES(QUARTER_CYCLES)
    ) i_bit_timer (
        .CLK         (CLK),
        .RESET       (RESET),
        .timer_run   (timer_run),
        .quarter_tick(quarter_tick),
        .phase       (phase)
    );

    eeprom_seq_fsm i_seq (
        .CLK  (CLK),
        .RESET(RESET),
        .wr   (wr),
        .rd   (rd),
        .addr (addr),
        .wdata(wdata),
        .rdata(rdata),
        .ack  (ack),
        .err  (err),
        .busy (busy),
        .bus  (bus.seq)
    );

    byte_engine i_engine (
        .CLK         (CLK),
        .RESET       (RESET),
        .bus         (bus.engine),
        .quarter_tick(quarter_tick),
        .phase       (phase),
        .timer_run   (timer_run),
        .scl         (scl),
        .sda_pull_low(sda_pull_low),
        .sda_in      (sda_in)
    );

endmodule

//--- rtl/serial_bus_if.sv
`timescale 1ns/10ps

interface serial_bus_if import eeprom_pkg::*; ();

    logic     cmd_valid;
    bus_cmd_t cmd;
    byte_t    tx_byte;
    logic     master_nack;   // drive 1 in the ack slot of a read byte

    logic     cmd_done;
    byte_t    rx_byte;
    logic     slave_ack;     // high means the slave did not acknowledge

    modport seq (
        output cmd_valid, cmd, tx_byte, master_nack,
        input  cmd_done, rx_byte, slave_ack
    );

    modport engine (
        input  cmd_valid, cmd, tx_byte, master_nack,
        output cmd_done, rx_byte, slave_ack
    );

endinterface

//--- run.sh
#!/usr/bin/env bash
# Build and run the EEPROM controller testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_eeprom_wr -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_eeprom_wr
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0

//--- tests/eeprom_model.sv
`timescale 1ns/10ps

module eeprom_model import eeprom_pkg::*; #(
    parameter int QUARTER_CYCLES = 2,
    parameter int BUSY_BITS      = 12
) (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic pull_low,
    output logic busy,
    output logic master_ack    // set once the master acks a read byte
);

    localparam int BUSY_CYCLES = BUSY_BITS * 4 * QUARTER_CYCLES;

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA,
        M_WAIT     // ignore the bus until the next start or stop
    } mode_t;

    mode_t     mode;
    logic      scl_q;
    logic      sda_q;
    logic [3:0] cnt;     // scl rises within the current byte, 9 = ack slot
    byte_t     shreg;
    byte_t     rd_byte;
    byte_t     wdata_q;
    mem_addr_t cur_addr;
    logic      rw;
    logic      wr_pending;
    int        busy_cnt;
    byte_t     mem [0:2047];

    logic start_cond;
    logic stop_cond;
    logic scl_rise;
    logic scl_fall;
    logic active;

    assign start_cond = scl && scl_q && sda_q && !sda;
    assign stop_cond  = scl && scl_q && !sda_q && sda;
    assign scl_rise   = scl && !scl_q;
    assign scl_fall   = !scl && scl_q;
    assign active     = (mode != M_IDLE) && (mode != M_WAIT);
    assign busy       = (busy_cnt != 0);

    // power-up contents depend on the full address
    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[mem_addr_t'(i)] = byte_t'(i ^ (i >> 3) ^ 'h5a);
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            mode       <= M_IDLE;
            cnt        <= '0;
            pull_low   <= 1'b0;
            busy_cnt   <= 0;
            wr_pending <= 1'b0;
            rw         <= 1'b0;
            cur_addr   <= '0;
            master_ack <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (busy_cnt != 0) begin
                busy_cnt <= busy_cnt - 1;
            end
            if (start_cond) begin
                mode       <= M_CTRL;
                cnt        <= '0;
                pull_low   <= 1'b0;
                wr_pending <= 1'b0;
            end else if (stop_cond) begin
                if (wr_pending) begin
                    mem[cur_addr] <= wdata_q;
                    busy_cnt      <= BUSY_CYCLES;   // internal write cycle
                end
                wr_pending <= 1'b0;
                mode       <= M_IDLE;
                pull_low   <= 1'b0;
            end else if (scl_rise && active) begin
                if (cnt < 4'd8) begin
                    shreg <= {shreg[6:0], sda};
                end else if (mode == M_RDATA && !sda) begin
                    master_ack <= 1'b1;    // single byte read must end with nack
                end
                cnt <= cnt + 4'd1;
            end else if (scl_fall && active) begin
                if (cnt == 4'd8) begin
                    case (mode)
                        M_CTRL: begin
                            if (shreg[7:4] == DEV_TYPE && busy_cnt == 0) begin
                                pull_low       <= 1'b1;
                                rw             <= shreg[0];
                                cur_addr[10:8] <= shreg[3:1];
                            end else begin
                                mode <= M_WAIT;    // no ack while busy
                            end
                        end
                        M_ADDR: begin
                            pull_low      <= 1'b1;
                            cur_addr[7:0] <= shreg;
                        end
                        M_WDATA: begin
                            pull_low   <= 1'b1;
                            wdata_q    <= shreg;
                            wr_pending <= 1'b1;
                        end
                        default: pull_low <= 1'b0;   // master owns this ack slot
                    endcase
                end else if (cnt == 4'd9) begin
                    cnt <= '0;
                    if (mode == M_CTRL && rw) begin
                        mode     <= M_RDATA;
                        rd_byte  <= mem[cur_addr];
                        pull_low <= !mem[cur_addr][7];
                    end else if (mode == M_CTRL) begin
                        mode     <= M_ADDR;
                        pull_low <= 1'b0;
                    end else if (mode == M_ADDR) begin
                        mode     <= M_WDATA;
                        pull_low <= 1'b0;
                    end else begin
                        mode     <= M_WAIT;
                        pull_low <= 1'b0;
                    end
                end else if (mode == M_RDATA) begin
                    pull_low <= !rd_byte[6];
                    rd_byte  <= {rd_byte[6:0], 1'b0};
                end
            end
        end
    end

endmodule

//--- tests/tb_eeprom_wr.sv
`timescale 1ns/10ps

module tb_eeprom_wr import eeprom_pkg::*; ();

    localparam int QUARTER_CYCLES = 2;
    localparam int BUSY_BITS      = 12;
    localparam int NUM_OPS        = 200;
    localparam int NUM_DIRECTED   = 16;
    // longest op is about 40 bit times, tripled for busy retries
    localparam int MAX_CYCLES = (NUM_OPS + NUM_DIRECTED) * 40 * 4 * QUARTER_CYCLES * 3;

    logic      CLK;
    logic      RESET;
    logic      wr;
    logic      rd;
    mem_addr_t addr;
    byte_t     wdata;
    byte_t     rdata;
    logic      ack;
    logic      err;
    logic      busy;
    logic      scl;
    logic      sda_pull_low;
    logic      model_pull;
    logic      model_busy;
    logic      model_master_ack;
    logic      sda_line;

    byte_t       ref_mem [0:2047];
    int          cycles = 0;
    int          nack_count = 0;
    logic [31:0] rng;

    assign sda_line = !(sda_pull_low || model_pull);   // wired-AND bus

    eeprom_wr_top #(
        .QUARTER_CYCLES(QUARTER_CYCLES)
    ) i_dut (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .ack         (ack),
        .err         (err),
        .busy        (busy),
        .scl         (scl),
        .sda_pull_low(sda_pull_low),
        .sda_in      (sda_line)
    );

    eeprom_model #(
        .QUARTER_CYCLES(QUARTER_CYCLES),
        .BUSY_BITS     (BUSY_BITS)
    ) i_model (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda_line),
        .pull_low  (model_pull),
        .busy      (model_busy),
        .master_ack(model_master_ack)
    );

    initial CLK = 1'b0;
    always #20 CLK = !CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("=== FAIL ===");
            $fatal(1, "timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic byte_t initial_byte(input int a);
        return byte_t'(a ^ (a >> 3) ^ 'h5a);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "check of %s failed", name);
        end
    endtask

    // one request from raise to ack, optionally disturbing the inputs mid-op
    task automatic run_op(input logic is_wr, input logic also_rd, input logic perturb,
                          input mem_addr_t a, input byte_t d, output logic op_err,
                          output byte_t op_rdata, output logic was_busy);
        @(posedge CLK);
        wr    <= is_wr;
        rd    <= !is_wr || also_rd;
        addr  <= a;
        wdata <= d;
        do @(negedge CLK); while (!busy);
        was_busy = model_busy;
        if (perturb) begin
            @(posedge CLK);
            addr  <= a ^ 11'h2a5;
            wdata <= ~d;
            rd    <= 1'b1;
        end
        do @(negedge CLK); while (!ack);
        op_err   = err;
        op_rdata = rdata;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic issue_op(input logic is_wr, input logic also_rd, input logic perturb,
                            input mem_addr_t a, input byte_t d, output byte_t op_rdata);
        logic op_err;
        logic was_busy;
        op_err = 1'b1;
        while (op_err) begin
            run_op(is_wr, also_rd, perturb, a, d, op_err, op_rdata, was_busy);
            if (!was_busy) begin
                check_value("err", 32'(op_err), 32'd0);   // idle slave must ack
            end
            check_value("model_master_ack", 32'(model_master_ack), 32'd0);
            if (op_err) begin
                nack_count++;
            end
        end
    endtask

    task automatic wait_model_idle();
        do @(negedge CLK); while (model_busy);
    endtask

    initial begin
        mem_addr_t a;
        mem_addr_t last_addr;
        byte_t     d;
        byte_t     got;
        logic      is_wr;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        rng   = 32'hbb28;
        last_addr = '0;
        for (int i = 0; i < 2048; i++) begin
            ref_mem[mem_addr_t'(i)] = initial_byte(i);
        end
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;

        @(negedge CLK);
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda_pull_low", 32'(sda_pull_low), 32'd0);
        check_value("ack", 32'(ack), 32'd0);
        check_value("busy", 32'(busy), 32'd0);

        // write then read back once the slave is idle
        for (int i = 0; i < 4; i++) begin
            rng = lcg_next(rng);
            a   = rng[30:20];
            d   = rng[15:8];
            issue_op(1'b1, 1'b0, 1'b0, a, d, got);
            ref_mem[a] = d;
            wait_model_idle();
            issue_op(1'b0, 1'b0, 1'b0, a, 8'h00, got);
            check_value("rdata", 32'(got), 32'(d));
        end

        // wr and rd together act as a write
        wait_model_idle();
        issue_op(1'b1, 1'b1, 1'b0, 11'h6c3, 8'h3e, got);
        ref_mem[11'h6c3] = 8'h3e;
        wait_model_idle();
        issue_op(1'b0, 1'b0, 1'b0, 11'h6c3, 8'h00, got);
        check_value("rdata", 32'(got), 32'h3e);

        // changed inputs during an op are ignored
        wait_model_idle();
        issue_op(1'b1, 1'b0, 1'b1, 11'h12f, 8'hc7, got);
        ref_mem[11'h12f] = 8'hc7;
        issue_op(1'b0, 1'b0, 1'b0, 11'h12f ^ 11'h2a5, 8'h00, got);
        check_value("rdata", 32'(got), 32'(ref_mem[11'h12f ^ 11'h2a5]));
        issue_op(1'b0, 1'b0, 1'b0, 11'h12f, 8'h00, got);
        check_value("rdata", 32'(got), 32'hc7);

        for (int n = 0; n < NUM_OPS; n++) begin
            rng   = lcg_next(rng);
            is_wr = rng[16];
            a     = rng[30:20];
            d     = rng[11:4];
            if (!is_wr && rng[14]) begin
                a = last_addr;      // read back a recent write
            end
            issue_op(is_wr, is_wr && rng[17] && rng[18], rng[19] && rng[15], a, d, got);
            if (is_wr) begin
                ref_mem[a] = d;
                last_addr  = a;
            end else begin
                check_value("rdata", 32'(got), 32'(ref_mem[a]));
            end
        end

        if (nack_count == 0) begin
            $display("=== FAIL ===");
            $fatal(1, "no operation ever met a busy slave");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule
